/* build.f */
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/scratch_ram.sv
rtl/plic_regs.sv
rtl/bus_responder.sv
rtl/soc_bus_top.sv
verification/tb_soc_bus.sv

/* rtl/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
    input  logic              clock_slow,
    input  logic              KEY0,
    input  soc_pkg::bus_req_t bus_req,
    input  logic              done_pulse,
    output soc_pkg::bus_sel_t sel
);

    logic             strobe;
    soc_pkg::region_e region_next;

    assign strobe = bus_req.rd | bus_req.wr;

    // region lookup from the address map
    always_comb begin
        region_next = soc_pkg::region_none;
        if (bus_req.addr >= soc_pkg::ram_base &&
            bus_req.addr < soc_pkg::ram_base + soc_pkg::ram_bytes) begin
            region_next = soc_pkg::region_ram;
        end else if (bus_req.addr == soc_pkg::key_addr) begin
            region_next = soc_pkg::region_key;
        end else if (bus_req.addr == soc_pkg::mtimecmp_addr) begin
            region_next = soc_pkg::region_mtimecmp;
        end else if (bus_req.addr >= soc_pkg::plic_base &&
                     bus_req.addr < soc_pkg::plic_base + soc_pkg::plic_span) begin
            region_next = soc_pkg::region_plic;
        end
    end

    // hold the request until the responder reports completion
    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            sel <= '0;
        end else if (strobe) begin
            sel.addr   <= bus_req.addr;
            sel.wdata  <= bus_req.wdata;
            sel.size   <= bus_req.size;
            sel.region <= region_next;
            sel.write  <= bus_req.wr;
            sel.active <= 1'b1;
        end else if (done_pulse) begin
            sel.active <= 1'b0;
        end
    end

    // one strobe kind at a time, and none while an access is still open
    ast_strobe_legal: assert property (
        @(posedge clock_slow) disable iff (!KEY0)
        !(bus_req.rd && bus_req.wr) && !(strobe && sel.active)
    ) else $error("bus_decoder: overlapping or double strobe");

endmodule

/* rtl/bus_responder.sv */
`timescale 1ns/1ps

module bus_responder (
    input  logic                     clock_slow,
    input  logic                     KEY0,
    input  soc_pkg::bus_sel_t        sel,
    input  soc_pkg::beat_t           ram_beat,
    input  soc_pkg::beat_t           plic_beat,
    input  logic [7:0]               key_ascii,
    output logic                     done_pulse,
    output logic [soc_pkg::xlen-1:0] read_data,
    output logic                     read_done,
    output logic                     write_done
);

    logic                     own_hit;
    logic [soc_pkg::xlen-1:0] own_data;
    logic [soc_pkg::xlen-1:0] rd_mux;
    logic [soc_pkg::xlen-1:0] mtimecmp;

    // key, mtimecmp and unmapped finish in one beat here
    assign own_hit = sel.active &&
        (sel.region inside {soc_pkg::region_none, soc_pkg::region_key,
                            soc_pkg::region_mtimecmp});

    assign done_pulse = own_hit | ram_beat.done | plic_beat.done;

    // done levels low while an access of that kind is open
    assign read_done = !(sel.active && !sel.write);
    assign write_done = !(sel.active && sel.write);

    always_comb begin
        case (sel.region)
            soc_pkg::region_key:      own_data = {56'd0, key_ascii};
            soc_pkg::region_mtimecmp: own_data = mtimecmp;
            default:                  own_data = '0;
        endcase
    end

    // one target at a time, so the beats OR together
    assign rd_mux = ram_beat.data | plic_beat.data | (own_hit ? own_data : '0);

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            read_data <= '0;
            mtimecmp <= soc_pkg::mtimecmp_reset;
        end else if (done_pulse) begin
            if (!sel.write) begin
                // read data moves only on the completion edge
                read_data <= rd_mux;
            end else if (sel.region == soc_pkg::region_mtimecmp) begin
                mtimecmp <= sel.wdata;
            end
        end
    end

endmodule

/* rtl/plic_regs.sv */
`timescale 1ns/1ps

module plic_regs (
    input  logic              clock_slow,
    input  logic              KEY0,
    input  soc_pkg::bus_sel_t sel,
    input  logic              ext_irq,
    output soc_pkg::beat_t    beat,
    output logic              meip,
    output logic              msip
);

    logic [soc_pkg::plic_prio_bits-1:0] prio [soc_pkg::plic_sources];
    logic [soc_pkg::plic_sources-1:0]   pending;
    logic [31:0]                        enable [2];
    logic [soc_pkg::plic_prio_bits-1:0] threshold [2];
    logic [soc_pkg::plic_id_bits-1:0]   claim_id [2];
    logic                               irq_d;
    logic                               is_plic;
    logic [soc_pkg::xlen-1:0]           offset;
    logic                               prio_hit;
    logic                               pend_hit;
    logic [1:0]                         en_hit;
    logic [1:0]                         thr_hit;
    logic [1:0]                         claim_hit;
    logic [soc_pkg::xlen-1:0]           rd_data;

    assign is_plic = sel.active && sel.region == soc_pkg::region_plic;
    assign offset = sel.addr - soc_pkg::plic_base;
    // priority words, 4 bytes per id
    assign prio_hit = offset < 64'(4 * soc_pkg::plic_sources);
    assign pend_hit = sel.addr == soc_pkg::plic_pending_addr;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_hit[c] = sel.addr ==
                soc_pkg::plic_enable_addr + 64'(c) * soc_pkg::plic_enable_stride;
            thr_hit[c] = sel.addr ==
                soc_pkg::plic_threshold_addr + 64'(c) * soc_pkg::plic_ctx_stride;
            claim_hit[c] = sel.addr ==
                soc_pkg::plic_claim_addr + 64'(c) * soc_pkg::plic_ctx_stride;
            // only the external source can be claimed
            claim_id[c] = (pending[soc_pkg::plic_ext_src] && enable[c][soc_pkg::plic_ext_src]) ?
                soc_pkg::plic_id_bits'(soc_pkg::plic_ext_src) : '0;
        end
    end

    assign meip = claim_id[0] != '0;
    assign msip = claim_id[1] != '0;

    // register read mux, unlisted offsets read zero
    always_comb begin
        rd_data = '0;
        if (prio_hit) rd_data = 64'(prio[offset[2 +: soc_pkg::plic_id_bits]]);
        if (pend_hit) rd_data = 64'(pending);
        for (int c = 0; c < 2; c++) begin
            if (en_hit[c]) rd_data = 64'(enable[c]);
            if (thr_hit[c]) rd_data = 64'(threshold[c]);
            if (claim_hit[c]) rd_data = 64'(claim_id[c]);
        end
    end

    assign beat.done = is_plic;
    assign beat.data = (is_plic && !sel.write) ? rd_data : '0;

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            irq_d <= 1'b0;
            pending <= '0;
            for (int i = 0; i < soc_pkg::plic_sources; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c] <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // rising edge of the external line
            irq_d <= ext_irq;
            if (ext_irq && !irq_d) pending[soc_pkg::plic_ext_src] <= 1'b1;
            if (is_plic && sel.write) begin
                if (prio_hit) begin
                    prio[offset[2 +: soc_pkg::plic_id_bits]] <=
                        sel.wdata[soc_pkg::plic_prio_bits-1:0];
                end
                for (int c = 0; c < 2; c++) begin
                    if (en_hit[c]) enable[c] <= sel.wdata[31:0];
                    if (thr_hit[c]) threshold[c] <= sel.wdata[soc_pkg::plic_prio_bits-1:0];
                end
            end else if (is_plic) begin
                // claim read retires the pending bit
                for (int c = 0; c < 2; c++) begin
                    if (claim_hit[c] && claim_id[c] != '0) pending[claim_id[c]] <= 1'b0;
                end
            end
        end
    end

    // a nonzero claim names a real source whose pending bit then retires
    ast_claim_range: assert property (
        @(posedge clock_slow) disable iff (!KEY0)
        (is_plic && !sel.write && |claim_hit && beat.data != '0) |=>
            $past(beat.data) < 64'(soc_pkg::plic_sources) &&
            !pending[$past(beat.data[soc_pkg::plic_id_bits-1:0])]
    ) else $error("plic_regs: claimed id out of range or still pending");

endmodule

/* rtl/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram (
    input  logic              clock_slow,
    input  logic              KEY0,
    input  soc_pkg::bus_sel_t sel,
    output soc_pkg::beat_t    beat
);

    logic [31:0]                       mem [soc_pkg::ram_words];
    logic [31:0]                       lo_word;
    logic                              beat_cnt;
    logic                              is_ram;
    logic                              is_dw;
    logic [1:0]                        off;
    logic [soc_pkg::ram_addr_bits-1:0] word_idx;
    logic [31:0]                       rd_word;
    logic [31:0]                       sh_word;
    logic [31:0]                       wr_word;
    logic [3:0]                        be;
    logic [soc_pkg::xlen-1:0]          ld_data;

    assign is_ram = sel.active && sel.region == soc_pkg::region_ram;
    assign is_dw = sel.size == soc_pkg::ls_ld;
    assign off = sel.addr[1:0];
    // second doubleword beat goes to the next word
    assign word_idx = sel.addr[2 +: soc_pkg::ram_addr_bits] +
        {{(soc_pkg::ram_addr_bits-1){1'b0}}, beat_cnt};
    assign rd_word = mem[word_idx];
    assign sh_word = rd_word >> {off, 3'b000};

    // store lanes and replicated write data
    always_comb begin
        be = 4'b1111;
        wr_word = sel.wdata[31:0];
        case (sel.size)
            soc_pkg::ls_lb: begin
                be = 4'b0001 << off;
                wr_word = {4{sel.wdata[7:0]}};
            end
            soc_pkg::ls_lh: begin
                be = 4'b0011 << off;
                wr_word = {2{sel.wdata[15:0]}};
            end
            soc_pkg::ls_ld: begin
                wr_word = beat_cnt ? sel.wdata[63:32] : sel.wdata[31:0];
            end
            default: begin
                be = 4'b1111;
            end
        endcase
    end

    // load extension by size code
    always_comb begin
        case (sel.size)
            soc_pkg::ls_lb:  ld_data = {{56{sh_word[7]}}, sh_word[7:0]};
            soc_pkg::ls_lh:  ld_data = {{48{sh_word[15]}}, sh_word[15:0]};
            soc_pkg::ls_lw:  ld_data = {{32{sh_word[31]}}, sh_word};
            soc_pkg::ls_ld:  ld_data = {rd_word, lo_word};
            soc_pkg::ls_lbu: ld_data = {56'd0, sh_word[7:0]};
            soc_pkg::ls_lhu: ld_data = {48'd0, sh_word[15:0]};
            soc_pkg::ls_lwu: ld_data = {32'd0, sh_word};
            default:         ld_data = '0;
        endcase
    end

    // doubleword waits one extra beat
    assign beat.done = is_ram && (!is_dw || beat_cnt);
    assign beat.data = (is_ram && !sel.write) ? ld_data : '0;

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            beat_cnt <= 1'b0;
        end else if (is_ram && is_dw) begin
            beat_cnt <= !beat_cnt;
        end
    end

    // array write and low word capture for ld
    always_ff @(posedge clock_slow) begin
        if (is_ram && sel.write) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
        if (is_ram && is_dw && !beat_cnt) begin
            lo_word <= rd_word;
        end
    end

    // alignment of the request as it arrived on the bus
    ast_ram_align: assert property (
        @(posedge clock_slow) disable iff (!KEY0)
        is_ram |-> (!is_dw || sel.addr[2:0] == 3'd0) &&
                   (!(sel.size inside {soc_pkg::ls_lh, soc_pkg::ls_lhu}) || !sel.addr[0])
    ) else $error("scratch_ram: misaligned access at %h", sel.addr);

endmodule

/* rtl/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                     clock_slow,
    input  logic                     KEY0,
    input  soc_pkg::bus_req_t        bus_req,
    input  logic [7:0]               key_ascii,
    input  logic                     ext_irq,
    output logic [soc_pkg::xlen-1:0] read_data,
    output logic                     read_done,
    output logic                     write_done,
    output logic                     meip,
    output logic                     msip
);

    soc_pkg::bus_sel_t sel;
    soc_pkg::beat_t    ram_beat;
    soc_pkg::beat_t    plic_beat;
    logic              done_pulse;

    // request capture and region decode
    bus_decoder u_bus_decoder (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .done_pulse (done_pulse),
        .sel        (sel)
    );

    scratch_ram u_scratch_ram (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .sel        (sel),
        .beat       (ram_beat)
    );

    plic_regs u_plic_regs (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .sel        (sel),
        .ext_irq    (ext_irq),
        .beat       (plic_beat),
        .meip       (meip),
        .msip       (msip)
    );

    // completion and read data back to the bus
    bus_responder u_bus_responder (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .sel        (sel),
        .ram_beat   (ram_beat),
        .plic_beat  (plic_beat),
        .key_ascii  (key_ascii),
        .done_pulse (done_pulse),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done)
    );

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

    // bus widths
    localparam int xlen = 64;
    localparam int ram_words = 512;
    localparam int ram_addr_bits = $clog2(ram_words);

    // address map
    localparam logic [xlen-1:0] ram_base = 64'h0000_0000_8000_0000;
    localparam logic [xlen-1:0] ram_bytes = 64'(ram_words * 4);
    localparam logic [xlen-1:0] key_addr = 64'h0000_0000_1000_0100;
    localparam logic [xlen-1:0] mtimecmp_addr = 64'h0000_0000_0200_4000;
    localparam logic [xlen-1:0] mtimecmp_reset = 64'h0000_0000_8000_0000;

    // interrupt controller map, contexts 0 and 1
    localparam logic [xlen-1:0] plic_base = 64'h0000_0000_0c00_0000;
    localparam logic [xlen-1:0] plic_span = 64'h0000_0000_0040_0000;
    localparam logic [xlen-1:0] plic_pending_addr = plic_base + 64'h1000;
    localparam logic [xlen-1:0] plic_enable_addr = plic_base + 64'h2000;
    localparam logic [xlen-1:0] plic_enable_stride = 64'h80;
    localparam logic [xlen-1:0] plic_threshold_addr = plic_base + 64'h20_0000;
    localparam logic [xlen-1:0] plic_claim_addr = plic_threshold_addr + 64'h4;
    localparam logic [xlen-1:0] plic_ctx_stride = 64'h1000;
    localparam int plic_sources = 6;
    localparam int plic_prio_bits = 3;
    localparam int plic_id_bits = $clog2(plic_sources);
    localparam int plic_ext_src = 1;

    // load/store size code, stores use 0..3
    typedef enum logic [2:0] {
        ls_lb  = 3'd0,
        ls_lh  = 3'd1,
        ls_lw  = 3'd2,
        ls_ld  = 3'd3,
        ls_lbu = 3'd4,
        ls_lhu = 3'd5,
        ls_lwu = 3'd6
    } ls_type_e;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        ls_type_e        size;
        logic            rd;
        logic            wr;
    } bus_req_t;

    typedef enum logic [2:0] {
        region_none     = 3'd0,
        region_ram      = 3'd1,
        region_key      = 3'd2,
        region_mtimecmp = 3'd3,
        region_plic     = 3'd4
    } region_e;

    // request as held for the duration of one access
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        ls_type_e        size;
        region_e         region;
        logic            write;
        logic            active;
    } bus_sel_t;

    typedef struct packed {
        logic            done;
        logic [xlen-1:0] data;
    } beat_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run tb_soc_bus with Verilator, then scan the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_soc_bus -f build.f -o tb_soc_bus \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_soc_bus > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
! grep -q "Test failed" sim.log || { echo "failure reported in sim.log"; exit 1; }
grep -q "Test passed" sim.log || { echo "run ended without a result line"; exit 1; }
echo "simulation finished clean"

/* verification/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;

    // about 330 accesses of 3 cycles each, plus interrupt idles and margin
    localparam int max_cycles = 4000;

    logic                     clock_slow;
    logic                     KEY0;
    soc_pkg::bus_req_t        bus_req;
    logic [7:0]               key_ascii;
    logic                     ext_irq;
    logic [soc_pkg::xlen-1:0] read_data;
    logic                     read_done;
    logic                     write_done;
    logic                     meip;
    logic                     msip;

    // shadow of the low 256 RAM bytes
    logic [7:0]  shadow [256];
    // check requests, each one sampled by its assertion at the next edge
    logic        chk_rd;
    logic        chk_lat;
    logic        chk_irq;
    logic [63:0] exp_rd;
    logic        exp_meip;
    logic        exp_msip;
    logic        lat_write;
    int          exp_lat;
    int          got_lat;
    int          err_data = 0;
    int          err_time = 0;
    int          err_irq = 0;
    int          cycles = 0;

    soc_bus_top u_soc_bus_top (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .key_ascii  (key_ascii),
        .ext_irq    (ext_irq),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .meip       (meip),
        .msip       (msip)
    );

    initial begin
        clock_slow = 1'b0;
        forever #50 clock_slow = ~clock_slow;
    end

    // run limit
    always @(posedge clock_slow) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("errors: data %0d, timing %0d, interrupt %0d", err_data, err_time, err_irq);
            $display("Test failed");
            $finish;
        end
    end

    a_read_data: assert property (@(posedge clock_slow) disable iff (!KEY0)
        chk_rd |-> read_data == exp_rd)
        else begin
            err_data++;
            $display("FAIL %0t read_data expected %h got %h", $time, exp_rd, read_data);
        end

    // done rise edge counted from the strobe edge
    a_latency: assert property (@(posedge clock_slow) disable iff (!KEY0)
        chk_lat |-> got_lat == exp_lat)
        else begin
            err_time++;
            $display("FAIL %0t %s rise edge expected %0d got %0d", $time,
                     lat_write ? "write_done" : "read_done", exp_lat, got_lat);
        end

    a_meip: assert property (@(posedge clock_slow) disable iff (!KEY0)
        chk_irq |-> meip == exp_meip)
        else begin
            err_irq++;
            $display("FAIL %0t meip expected %b got %b", $time, exp_meip, meip);
        end

    a_msip: assert property (@(posedge clock_slow) disable iff (!KEY0)
        chk_irq |-> msip == exp_msip)
        else begin
            err_irq++;
            $display("FAIL %0t msip expected %b got %b", $time, exp_msip, msip);
        end

    // bus idle between accesses
    a_idle_done: assert property (@(posedge clock_slow) disable iff (!KEY0)
        chk_irq |-> read_done && write_done)
        else begin
            err_time++;
            $display("FAIL %0t read_done/write_done expected 1/1 got %b/%b", $time,
                     read_done, write_done);
        end

    a_rd_drop: assert property (@(posedge clock_slow) disable iff (!KEY0)
        bus_req.rd |=> !read_done)
        else begin
            err_time++;
            $display("FAIL %0t read_done expected 0 got %b", $time, read_done);
        end

    a_wr_drop: assert property (@(posedge clock_slow) disable iff (!KEY0)
        bus_req.wr |=> !write_done)
        else begin
            err_time++;
            $display("FAIL %0t write_done expected 0 got %b", $time, write_done);
        end

    // read data may only move with a read completion
    a_rdata_hold: assert property (@(posedge clock_slow) disable iff (!KEY0)
        !$rose(read_done) |-> $stable(read_data))
        else begin
            err_data++;
            $display("read_data changed without a read completion at %0t", $time);
        end

    // little endian byte model of a store
    function automatic void record_store(input int a, input logic [2:0] size,
                                         input logic [63:0] data);
        for (int i = 0; i < (1 << size[1:0]); i++) begin
            shadow[a + i] = data[8*i +: 8];
        end
    endfunction

    // gather the bytes, then extend for the signed codes 0 to 2
    function automatic logic [63:0] expected_load(input int a, input logic [2:0] size);
        logic [63:0] raw;
        int          n;
        raw = '0;
        n = 1 << size[1:0];
        for (int i = 0; i < n; i++) begin
            raw[8*i +: 8] = shadow[a + i];
        end
        if (!size[2] && n < 8 && raw[8*n-1]) begin
            raw = raw | (64'hffff_ffff_ffff_ffff << (8 * n));
        end
        return raw;
    endfunction

    // one edge, drives land 5 ns after it, old check requests retire
    task automatic advance_cycle();
        @(posedge clock_slow);
        #5;
        chk_rd = 1'b0;
        chk_lat = 1'b0;
        chk_irq = 1'b0;
    endtask

    task automatic issue_access(input logic [63:0] addr, input logic [63:0] wdata,
                                input logic [2:0] size, input logic write,
                                input logic check, input logic [63:0] expected);
        int edges;
        int want;
        // doubleword RAM access needs a second beat
        want = 2;
        if (addr >= soc_pkg::ram_base && addr < soc_pkg::ram_base + soc_pkg::ram_bytes &&
            size == 3'd3) begin
            want = 3;
        end
        advance_cycle();
        bus_req.addr = addr;
        bus_req.wdata = wdata;
        bus_req.size = soc_pkg::ls_type_e'(size);
        bus_req.rd = !write;
        bus_req.wr = write;
        @(posedge clock_slow);
        #5;
        bus_req.rd = 1'b0;
        bus_req.wr = 1'b0;
        edges = 1;
        // run limit covers a done that never rises
        do begin
            @(posedge clock_slow);
            #1;
            edges++;
        end while (!(write ? write_done : read_done));
        lat_write = write;
        exp_lat = want;
        got_lat = edges;
        chk_lat = 1'b1;
        if (check) begin
            exp_rd = expected;
            chk_rd = 1'b1;
        end
    endtask

    task automatic write_value(input logic [63:0] addr, input logic [63:0] data,
                               input logic [2:0] size);
        issue_access(addr, data, size, 1'b1, 1'b0, '0);
    endtask

    task automatic read_expect(input logic [63:0] addr, input logic [2:0] size,
                               input logic [63:0] expected);
        issue_access(addr, '0, size, 1'b0, 1'b1, expected);
    endtask

    task automatic pulse_irq();
        advance_cycle();
        ext_irq = 1'b1;
        advance_cycle();
        ext_irq = 1'b0;
        advance_cycle();
    endtask

    task automatic expect_irq(input logic m, input logic s);
        advance_cycle();
        exp_meip = m;
        exp_msip = s;
        chk_irq = 1'b1;
    endtask

    initial begin
        logic [63:0] wd;
        logic [63:0] en1;
        logic [63:0] thr1;
        logic [63:0] claim1;
        logic [2:0]  sz;
        logic [2:0]  lc;
        logic [7:0]  key;
        int          a;
        int          la;
        KEY0 = 1'b0;
        bus_req = '0;
        key_ascii = 8'd0;
        ext_irq = 1'b0;
        chk_rd = 1'b0;
        chk_lat = 1'b0;
        chk_irq = 1'b0;
        exp_rd = '0;
        exp_meip = 1'b0;
        exp_msip = 1'b0;
        lat_write = 1'b0;
        exp_lat = 0;
        got_lat = 0;
        en1 = soc_pkg::plic_enable_addr + soc_pkg::plic_enable_stride;
        thr1 = soc_pkg::plic_threshold_addr + soc_pkg::plic_ctx_stride;
        claim1 = soc_pkg::plic_claim_addr + soc_pkg::plic_ctx_stride;
        void'($urandom(32'hfbf87ed0));
        repeat (3) @(posedge clock_slow);
        #5;
        KEY0 = 1'b1;

        // reset state, then mtimecmp round trip
        exp_rd = '0;
        chk_rd = 1'b1;
        expect_irq(1'b0, 1'b0);
        read_expect(soc_pkg::mtimecmp_addr, 3'd3, soc_pkg::mtimecmp_reset);
        wd = {$urandom(), $urandom()};
        write_value(soc_pkg::mtimecmp_addr, wd, 3'd3);
        read_expect(soc_pkg::mtimecmp_addr, 3'd3, wd);

        // fill the low 256 bytes by doublewords, each read back
        for (int d = 0; d < 256; d += 8) begin
            wd = {$urandom(), $urandom()};
            write_value(soc_pkg::ram_base + 64'(d), wd, 3'd3);
            record_store(d, 3'd3, wd);
            read_expect(soc_pkg::ram_base + 64'(d), 3'd3, expected_load(d, 3'd3));
        end

        // random b, h, w stores, each followed by every load code
        for (int s = 0; s < 30; s++) begin
            sz = 3'($urandom_range(2, 0));
            a = $urandom_range(255, 0);
            a = a & ~((1 << sz) - 1);
            wd = {$urandom(), $urandom()};
            write_value(soc_pkg::ram_base + 64'(a), wd, sz);
            record_store(a, sz, wd);
            for (int c = 0; c < 7; c++) begin
                lc = 3'(c);
                la = a & ~((1 << lc[1:0]) - 1);
                read_expect(soc_pkg::ram_base + 64'(la), lc, expected_load(la, lc));
            end
        end

        // context 0 takes the source
        write_value(soc_pkg::plic_enable_addr, 64'h2, 3'd2);
        write_value(en1, 64'h0, 3'd2);
        pulse_irq();
        expect_irq(1'b1, 1'b0);
        read_expect(soc_pkg::plic_claim_addr, 3'd2, 64'd1);
        expect_irq(1'b0, 1'b0);
        // context 1 takes the source
        write_value(soc_pkg::plic_enable_addr, 64'h0, 3'd2);
        write_value(en1, 64'h2, 3'd2);
        pulse_irq();
        expect_irq(1'b0, 1'b1);
        read_expect(claim1, 3'd2, 64'd1);
        expect_irq(1'b0, 1'b0);

        // priority and threshold keep 3 bits
        wd = 64'($urandom());
        write_value(soc_pkg::plic_base + 64'd4, wd, 3'd2);
        read_expect(soc_pkg::plic_base + 64'd4, 3'd2, wd & 64'h7);
        wd = 64'($urandom());
        write_value(soc_pkg::plic_base + 64'd12, wd, 3'd2);
        read_expect(soc_pkg::plic_base + 64'd12, 3'd2, wd & 64'h7);
        wd = 64'($urandom());
        write_value(soc_pkg::plic_threshold_addr, wd, 3'd2);
        read_expect(soc_pkg::plic_threshold_addr, 3'd2, wd & 64'h7);
        wd = 64'($urandom());
        write_value(thr1, wd, 3'd2);
        read_expect(thr1, 3'd2, wd & 64'h7);
        wd = 64'($urandom());
        write_value(soc_pkg::plic_enable_addr, wd, 3'd2);
        read_expect(soc_pkg::plic_enable_addr, 3'd2, wd);
        write_value(soc_pkg::plic_enable_addr, 64'h0, 3'd2);
        write_value(en1, 64'h0, 3'd2);
        // pending holds across a claim write
        pulse_irq();
        read_expect(soc_pkg::plic_pending_addr, 3'd2, 64'h2);
        write_value(soc_pkg::plic_claim_addr, 64'd1, 3'd2);
        read_expect(soc_pkg::plic_pending_addr, 3'd2, 64'h2);

        // key code and an unmapped address
        key = 8'($urandom()) | 8'h80;
        advance_cycle();
        key_ascii = key;
        read_expect(soc_pkg::key_addr, 3'd4, {56'd0, key});
        read_expect(64'h0000_0000_4000_0000, 3'd2, 64'd0);
        write_value(64'h0000_0000_4000_0000, 64'h1234, 3'd2);

        advance_cycle();
        advance_cycle();
        $display("errors: data %0d, timing %0d, interrupt %0d", err_data, err_time, err_irq);
        if (err_data + err_time + err_irq == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
